// ==== source/soc_pkg.sv ====
package soc_pkg;

	// Bus widths
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;
	localparam int SELBITSZ  = ARCHBITSZ / 8;

	// Bus operations
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		PI1_RWOP = 2'b11
	} pi1_op_t;

	// Slave slots, laid out from address 0 in this order
	localparam int S_DEVTBL     = 0;
	localparam int S_GPIO       = 1;
	localparam int S_INVALIDDEV = 2;
	localparam int SLAVECOUNT   = 3;
	localparam int SLOTBITSZ    = $clog2(SLAVECOUNT);

	// Map sizes in bytes
	localparam int DEVTBL_MAPSZ     = 'h1000;
	localparam int GPIO_MAPSZ       = 'h1000;
	localparam int INVALIDDEV_MAPSZ = 'h1000;

	// Slot bases as word addresses
	localparam logic [ADDRBITSZ-1:0] DEVTBL_BASE     = '0;
	localparam logic [ADDRBITSZ-1:0] GPIO_BASE       =
		DEVTBL_BASE + ADDRBITSZ'(DEVTBL_MAPSZ / SELBITSZ);
	localparam logic [ADDRBITSZ-1:0] INVALIDDEV_BASE =
		GPIO_BASE + ADDRBITSZ'(GPIO_MAPSZ / SELBITSZ);

	localparam int DEVID_DEVTBL  = 7;
	localparam int DEVID_GPIO    = 6;
	localparam int DEVID_INVALID = 0;

	localparam int USEINTR_DEVTBL  = 0;
	localparam int USEINTR_GPIO    = 1;
	localparam int USEINTR_INVALID = 0;

	localparam int SOCID               = 4;
	localparam int GPIOCOUNT           = 8;
	localparam int RST_CNTR_BITSZ_DFLT = 20;

	// Device table word offsets
	localparam int DT_RST   = 0;
	localparam int DT_SOCID = 1;
	localparam int DT_COUNT = 2;
	localparam int DT_ENTRY = 4;

	// GPIO word offsets
	localparam int GP_IN   = 0;
	localparam int GP_OUT  = 1;
	localparam int GP_MASK = 2;

	// Per-slot table contents, slot 0 in the lowest word
	localparam logic [SLAVECOUNT-1:0][ARCHBITSZ-1:0] DT_ID_TBL = {
		ARCHBITSZ'(DEVID_INVALID),
		ARCHBITSZ'(DEVID_GPIO),
		ARCHBITSZ'(DEVID_DEVTBL)
	};
	localparam logic [SLAVECOUNT-1:0][ARCHBITSZ-1:0] DT_MAPSZ_TBL = {
		ARCHBITSZ'(INVALIDDEV_MAPSZ | USEINTR_INVALID),
		ARCHBITSZ'(GPIO_MAPSZ | USEINTR_GPIO),
		ARCHBITSZ'(DEVTBL_MAPSZ | USEINTR_DEVTBL)
	};

endpackage

// ==== source/pi1_if.sv ====
interface pi1_if;
	import soc_pkg::*;

	pi1_op_t               op;
	logic [ADDRBITSZ-1:0]  addr;
	logic [ARCHBITSZ-1:0]  data_w;
	logic [SELBITSZ-1:0]   sel;
	logic [ARCHBITSZ-1:0]  data_r;
	logic                  rdy;

	// Issues accesses and holds them until rdy
	modport master (
		output op,
		output addr,
		output data_w,
		output sel,
		input  data_r,
		input  rdy
	);

	modport slave (
		input  op,
		input  addr,
		input  data_w,
		input  sel,
		output data_r,
		output rdy
	);

endinterface

// ==== source/reset_seq.sv ====
module reset_seq #(
	parameter int RST_CNTR_BITSZ = soc_pkg::RST_CNTR_BITSZ_DFLT
) (
	input  logic clk_4x_w,
	input  logic rst_p,
	input  logic warm_rst_req_i,
	input  logic pwroff_req_i,
	output logic sys_rst_o,
	output logic poweroff_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_q;
	logic                      cntr_busy;

	assign cntr_busy = |rst_cntr;

	// Countdown restarts from all ones on external or warm reset,
	// then runs to zero and stops there
	always_ff @(posedge clk_4x_w) begin
		if (rst_p || warm_rst_req_i) begin
			rst_cntr <= '1;
		end else if (cntr_busy) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off latch, released only by the external reset
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req_i) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o  = cntr_busy || pwroff_q;
	assign poweroff_o = pwroff_q;

endmodule

// ==== source/pi1_router.sv ====
module pi1_router (
	input logic clk_4x_w,
	input logic sys_rst_i,
	pi1_if.slave  up,
	pi1_if.master dt,
	pi1_if.master gp
);
	import soc_pkg::*;

	logic [SLOTBITSZ-1:0] slot_sel;
	logic [SLOTBITSZ-1:0] slot_q;
	logic                 slot_rdy;
	logic                 accept;

	// Address decode, anything past the GPIO region lands on the invalid slot
	always_comb begin
		if (up.addr < GPIO_BASE) begin
			slot_sel = SLOTBITSZ'(S_DEVTBL);
		end else if (up.addr < INVALIDDEV_BASE) begin
			slot_sel = SLOTBITSZ'(S_GPIO);
		end else begin
			slot_sel = SLOTBITSZ'(S_INVALIDDEV);
		end
	end

	// Only the selected slave sees the op
	assign dt.op     = (slot_sel == SLOTBITSZ'(S_DEVTBL)) ? up.op : PI1_NOOP;
	assign dt.addr   = up.addr - DEVTBL_BASE;
	assign dt.data_w = up.data_w;
	assign dt.sel    = up.sel;

	assign gp.op     = (slot_sel == SLOTBITSZ'(S_GPIO)) ? up.op : PI1_NOOP;
	assign gp.addr   = up.addr - GPIO_BASE;
	assign gp.data_w = up.data_w;
	assign gp.sel    = up.sel;

	// Invalid slot is always ready
	always_comb begin
		case (slot_sel)
			SLOTBITSZ'(S_DEVTBL): slot_rdy = dt.rdy;
			SLOTBITSZ'(S_GPIO):   slot_rdy = gp.rdy;
			default:              slot_rdy = 1'b1;
		endcase
	end

	assign up.rdy = !sys_rst_i && slot_rdy;
	assign accept = (up.op != PI1_NOOP) && up.rdy;

	// Remember which slave answers the read data in the next cycle
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			slot_q <= SLOTBITSZ'(S_INVALIDDEV);
		end else if (accept) begin
			slot_q <= slot_sel;
		end
	end

	// Invalid slot reads as zero
	always_comb begin
		case (slot_q)
			SLOTBITSZ'(S_DEVTBL): up.data_r = dt.data_r;
			SLOTBITSZ'(S_GPIO):   up.data_r = gp.data_r;
			default:              up.data_r = '0;
		endcase
	end

endmodule

// ==== source/devtbl.sv ====
module devtbl (
	input  logic clk_4x_w,
	input  logic sys_rst_i,
	pi1_if.slave bus,
	output logic warm_rst_req_o,
	output logic pwroff_req_o
);
	import soc_pkg::*;

	logic                 accept;
	logic                 rd_en;
	logic                 rst_wr;
	logic                 in_entries;
	logic [ADDRBITSZ-1:0] ent_off;
	logic [SLOTBITSZ-1:0] ent_idx;
	logic [ARCHBITSZ-1:0] rd_word;
	logic [ARCHBITSZ-1:0] data_r_q;
	logic                 warm_q;
	logic                 pwroff_q;

	assign bus.rdy = !sys_rst_i;
	assign accept  = (bus.op != PI1_NOOP) && bus.rdy;
	assign rd_en   = accept && ((bus.op == PI1_RDOP) || (bus.op == PI1_RWOP));

	// Reset request only when byte 0 is written
	assign rst_wr = accept && ((bus.op == PI1_WROP) || (bus.op == PI1_RWOP)) &&
		(bus.addr == ADDRBITSZ'(DT_RST)) && bus.sel[0];

	// Two words per slot, id first then map size with the interrupt flag
	assign ent_off    = bus.addr - ADDRBITSZ'(DT_ENTRY);
	assign ent_idx    = ent_off[SLOTBITSZ:1];
	assign in_entries = (bus.addr >= ADDRBITSZ'(DT_ENTRY)) &&
		(bus.addr < ADDRBITSZ'(DT_ENTRY + 2 * SLAVECOUNT));

	always_comb begin
		rd_word = '0;
		if (bus.addr == ADDRBITSZ'(DT_SOCID)) begin
			rd_word = ARCHBITSZ'(SOCID);
		end else if (bus.addr == ADDRBITSZ'(DT_COUNT)) begin
			rd_word = ARCHBITSZ'(SLAVECOUNT);
		end else if (in_entries) begin
			if (ent_off[0]) begin
				rd_word = DT_MAPSZ_TBL[ent_idx];
			end else begin
				rd_word = DT_ID_TBL[ent_idx];
			end
		end
	end

	// DT_RST is write only, so an RWOP there returns zero
	always_ff @(posedge clk_4x_w) begin
		if (rd_en) begin
			data_r_q <= rd_word;
		end
	end

	assign bus.data_r = data_r_q;

	// rst1 requests a warm reset whatever rst0 is, rst0 alone is power-off
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			warm_q   <= 1'b0;
			pwroff_q <= 1'b0;
		end else begin
			warm_q   <= rst_wr && bus.data_w[1];
			pwroff_q <= rst_wr && bus.data_w[0] && !bus.data_w[1];
		end
	end

	assign warm_rst_req_o = warm_q;
	assign pwroff_req_o   = pwroff_q;

endmodule

// ==== source/gpio_ctrl.sv ====
module gpio_ctrl (
	input  logic                           clk_4x_w,
	input  logic                           sys_rst_i,
	pi1_if.slave                           bus,
	input  logic [soc_pkg::GPIOCOUNT-1:0]  gp_i,
	output logic [soc_pkg::GPIOCOUNT-1:0]  gp_o,
	output logic                           irq_o,
	input  logic                           irq_ack_i
);
	import soc_pkg::*;

	logic                 accept;
	logic                 rd_en;
	logic                 wr_en;
	logic [GPIOCOUNT-1:0] gp_s1;
	logic [GPIOCOUNT-1:0] gp_s2;
	logic [GPIOCOUNT-1:0] gp_prev;
	logic [GPIOCOUNT-1:0] out_q;
	logic [GPIOCOUNT-1:0] mask_q;
	logic [ARCHBITSZ-1:0] rd_word;
	logic [ARCHBITSZ-1:0] wr_word;
	logic [ARCHBITSZ-1:0] data_r_q;
	logic                 change;
	logic                 irq_q;

	// Replace only the bytes whose select bit is set
	function automatic logic [ARCHBITSZ-1:0] byte_merge(
		input logic [ARCHBITSZ-1:0] old_w,
		input logic [ARCHBITSZ-1:0] new_w,
		input logic [SELBITSZ-1:0]  sel_w
	);
		logic [ARCHBITSZ-1:0] res;
		res = old_w;
		for (int i = 0; i < SELBITSZ; i++) begin
			if (sel_w[i])
				res[i*8 +: 8] = new_w[i*8 +: 8];
		end
		return res;
	endfunction

	assign bus.rdy = !sys_rst_i;
	assign accept  = (bus.op != PI1_NOOP) && bus.rdy;
	assign rd_en   = accept && ((bus.op == PI1_RDOP) || (bus.op == PI1_RWOP));
	assign wr_en   = accept && ((bus.op == PI1_WROP) || (bus.op == PI1_RWOP));

	// Two-stage synchronizer plus last-cycle copy for edge detection
	always_ff @(posedge clk_4x_w) begin
		gp_s1   <= gp_i;
		gp_s2   <= gp_s1;
		gp_prev <= gp_s2;
	end

	always_comb begin
		case (bus.addr)
			ADDRBITSZ'(GP_IN):   rd_word = ARCHBITSZ'(gp_s2);
			ADDRBITSZ'(GP_OUT):  rd_word = ARCHBITSZ'(out_q);
			ADDRBITSZ'(GP_MASK): rd_word = ARCHBITSZ'(mask_q);
			default:             rd_word = '0;
		endcase
	end

	// Merge against the addressed register's current value
	assign wr_word = byte_merge(rd_word, bus.data_w, bus.sel);

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
		end else if (wr_en) begin
			if (bus.addr == ADDRBITSZ'(GP_OUT))
				out_q <= wr_word[GPIOCOUNT-1:0];
			if (bus.addr == ADDRBITSZ'(GP_MASK))
				mask_q <= wr_word[GPIOCOUNT-1:0];
		end
	end

	// RWOP captures the value from before its own write
	always_ff @(posedge clk_4x_w) begin
		if (rd_en) begin
			data_r_q <= rd_word;
		end
	end

	assign bus.data_r = data_r_q;
	assign gp_o       = out_q;

	assign change = |((gp_s2 ^ gp_prev) & mask_q);

	// A new change beats an ack in the same cycle
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			irq_q <= 1'b0;
		end else if (change) begin
			irq_q <= 1'b1;
		end else if (irq_ack_i) begin
			irq_q <= 1'b0;
		end
	end

	assign irq_o = irq_q;

endmodule

// ==== source/soc_top.sv ====
module soc_top #(
	parameter int RST_CNTR_BITSZ = soc_pkg::RST_CNTR_BITSZ_DFLT
) (
	input  logic                           clk_4x_w,
	input  logic                           rst_p,
	input  soc_pkg::pi1_op_t               pi1_op_i,
	input  logic [soc_pkg::ADDRBITSZ-1:0]  pi1_addr_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]  pi1_data_i,
	input  logic [soc_pkg::SELBITSZ-1:0]   pi1_sel_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]  pi1_data_o,
	output logic                           pi1_rdy_o,
	input  logic [soc_pkg::GPIOCOUNT-1:0]  gp_i,
	output logic [soc_pkg::GPIOCOUNT-1:0]  gp_o,
	output logic                           irq_o,
	input  logic                           irq_ack_i,
	output logic                           sys_rst_o,
	output logic                           poweroff_o
);

	logic sys_rst;
	logic warm_rst_req;
	logic pwroff_req;

	pi1_if up_bus ();
	pi1_if dt_bus ();
	pi1_if gp_bus ();

	// Bus master ports onto the upstream interface
	assign up_bus.op     = pi1_op_i;
	assign up_bus.addr   = pi1_addr_i;
	assign up_bus.data_w = pi1_data_i;
	assign up_bus.sel    = pi1_sel_i;
	assign pi1_data_o    = up_bus.data_r;
	assign pi1_rdy_o     = up_bus.rdy;
	assign sys_rst_o     = sys_rst;

	reset_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) reset_seq_i (
		.clk_4x_w       (clk_4x_w),
		.rst_p          (rst_p),
		.warm_rst_req_i (warm_rst_req),
		.pwroff_req_i   (pwroff_req),
		.sys_rst_o      (sys_rst),
		.poweroff_o     (poweroff_o)
	);

	pi1_router pi1_router_i (
		.clk_4x_w  (clk_4x_w),
		.sys_rst_i (sys_rst),
		.up        (up_bus.slave),
		.dt        (dt_bus.master),
		.gp        (gp_bus.master)
	);

	devtbl devtbl_i (
		.clk_4x_w       (clk_4x_w),
		.sys_rst_i      (sys_rst),
		.bus            (dt_bus.slave),
		.warm_rst_req_o (warm_rst_req),
		.pwroff_req_o   (pwroff_req)
	);

	gpio_ctrl gpio_ctrl_i (
		.clk_4x_w  (clk_4x_w),
		.sys_rst_i (sys_rst),
		.bus       (gp_bus.slave),
		.gp_i      (gp_i),
		.gp_o      (gp_o),
		.irq_o     (irq_o),
		.irq_ack_i (irq_ack_i)
	);

endmodule

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Reset covers the first two rising edges and drops on a falling edge
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

// ==== sim/tb_soc_top.sv ====
module tb_soc_top;
	import soc_pkg::*;

	localparam int CNTR_BITSZ = 4;
	localparam int RST_CYCLES = (1 << CNTR_BITSZ) - 1;
	localparam int WAIT_LIMIT = 100;
	// Word bases of the GPIO and invalid regions from the byte map sizes
	localparam logic [ADDRBITSZ-1:0] GP_WBASE  = ADDRBITSZ'(DEVTBL_MAPSZ / 4);
	localparam logic [ADDRBITSZ-1:0] INV_WBASE = ADDRBITSZ'((DEVTBL_MAPSZ + GPIO_MAPSZ) / 4);
	localparam int W_SYS_RST  = 0;
	localparam int W_POWEROFF = 1;
	localparam int W_IRQ      = 2;
	localparam int W_RST_P    = 3;

	logic                 clk_4x_w;
	logic                 gen_rst;
	logic                 tb_rst;
	logic                 rst_p;
	pi1_op_t              pi1_op_i;
	logic [ADDRBITSZ-1:0] pi1_addr_i;
	logic [ARCHBITSZ-1:0] pi1_data_i;
	logic [SELBITSZ-1:0]  pi1_sel_i;
	logic [ARCHBITSZ-1:0] pi1_data_o;
	logic                 pi1_rdy_o;
	logic [GPIOCOUNT-1:0] gp_i;
	logic [GPIOCOUNT-1:0] gp_o;
	logic                 irq_o;
	logic                 irq_ack_i;
	logic                 sys_rst_o;
	logic                 poweroff_o;
	int                   check_errs = 0;
	int                   timeout_errs = 0;
	int                   last_stall;
	logic [15:0]          lfsr_q;

	assign rst_p = gen_rst || tb_rst;

	tb_clk_gen clk_gen_i (
		.clk_o (clk_4x_w),
		.rst_o (gen_rst)
	);

	soc_top #(
		.RST_CNTR_BITSZ (CNTR_BITSZ)
	) soc_top_i (
		.clk_4x_w   (clk_4x_w),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.gp_i       (gp_i),
		.gp_o       (gp_o),
		.irq_o      (irq_o),
		.irq_ack_i  (irq_ack_i),
		.sys_rst_o  (sys_rst_o),
		.poweroff_o (poweroff_o)
	);

	assert property (@(posedge clk_4x_w) pi1_rdy_o == !sys_rst_o)
		else begin
			check_errs++;
			$display("[FAIL] %0t: pi1_rdy_o does not follow sys_rst_o", $time);
		end

	assert property (@(posedge clk_4x_w) poweroff_o |-> sys_rst_o)
		else begin
			check_errs++;
			$display("[FAIL] %0t: sys_rst_o low while powered off", $time);
		end

	// Interrupt only drops on an acknowledge
	assert property (@(posedge clk_4x_w) disable iff (rst_p || sys_rst_o)
		irq_o && !irq_ack_i |=> irq_o)
		else begin
			check_errs++;
			$display("[FAIL] %0t: irq_o dropped without acknowledge", $time);
		end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit with the LSB taken first
	task automatic take_random(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val[i] = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic expect_true(input logic ok, input string msg);
		assert (ok) else begin
			check_errs++;
			$display("[FAIL] %0t: %s", $time, msg);
		end
	endtask

	function automatic logic probe(input int which);
		case (which)
			W_SYS_RST:  return sys_rst_o;
			W_POWEROFF: return poweroff_o;
			W_IRQ:      return irq_o;
			default:    return rst_p;
		endcase
	endfunction

	// Counts falling edges until the watched signal reaches the level
	task automatic wait_level(input int which, input logic level, input int start,
		output int cycles);
		cycles = start;
		while (probe(which) != level && cycles < WAIT_LIMIT) begin
			@(negedge clk_4x_w);
			cycles++;
		end
		if (probe(which) != level) begin
			timeout_errs++;
			$display("Timeout: signal %0d never reached level %0b", which, level);
		end
	endtask

	task automatic bus_access(
		input  pi1_op_t              op,
		input  logic [ADDRBITSZ-1:0] addr,
		input  logic [ARCHBITSZ-1:0] wdata,
		input  logic [SELBITSZ-1:0]  sel,
		output logic [ARCHBITSZ-1:0] rdata
	);
		int waited;
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = wdata;
		pi1_sel_i  = sel;
		waited     = 0;
		// Low rdy holds the access until a later edge
		while (!pi1_rdy_o && waited < WAIT_LIMIT) begin
			@(negedge clk_4x_w);
			waited++;
		end
		if (!pi1_rdy_o) begin
			timeout_errs++;
			$display("Timeout: access to address %h was never accepted", addr);
		end
		last_stall = waited;
		@(negedge clk_4x_w);
		pi1_op_i = PI1_NOOP;
		rdata    = pi1_data_o;
	endtask

	task automatic read_word(input logic [ADDRBITSZ-1:0] addr,
		output logic [ARCHBITSZ-1:0] rdata);
		bus_access(PI1_RDOP, addr, '0, '1, rdata);
	endtask

	task automatic write_word(input logic [ADDRBITSZ-1:0] addr,
		input logic [ARCHBITSZ-1:0] wdata, input logic [SELBITSZ-1:0] sel);
		logic [ARCHBITSZ-1:0] ignored;
		bus_access(PI1_WROP, addr, wdata, sel, ignored);
	endtask

	initial begin
		logic [ARCHBITSZ-1:0] rd;
		logic [ARCHBITSZ-1:0] rnd;
		logic [ARCHBITSZ-1:0] wdat;
		logic [SELBITSZ-1:0]  sel;
		logic [GPIOCOUNT-1:0] exp_out;
		logic [ADDRBITSZ-1:0] inv_addr;
		logic [ARCHBITSZ-1:0] exp_id [SLAVECOUNT];
		logic [ARCHBITSZ-1:0] exp_sz [SLAVECOUNT];
		int                   cnt;

		pi1_op_i   = PI1_NOOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		gp_i       = '0;
		irq_ack_i  = 1'b0;
		tb_rst     = 1'b0;
		lfsr_q     = 16'd68;
		exp_id[0]  = ARCHBITSZ'(DEVID_DEVTBL);
		exp_id[1]  = ARCHBITSZ'(DEVID_GPIO);
		exp_id[2]  = ARCHBITSZ'(DEVID_INVALID);
		exp_sz[0]  = ARCHBITSZ'(DEVTBL_MAPSZ | USEINTR_DEVTBL);
		exp_sz[1]  = ARCHBITSZ'(GPIO_MAPSZ | USEINTR_GPIO);
		exp_sz[2]  = ARCHBITSZ'(INVALIDDEV_MAPSZ | USEINTR_INVALID);

		// One rising edge has passed by the time rst_p is seen low
		@(negedge clk_4x_w);
		wait_level(W_RST_P, 1'b0, 0, cnt);
		expect_true(sys_rst_o && !pi1_rdy_o && gp_o == '0 && !irq_o && !poweroff_o &&
			pi1_data_o == '0, "outputs wrong right after reset");
		wait_level(W_SYS_RST, 1'b0, 1, cnt);
		expect_true(cnt == RST_CYCLES, $sformatf("reset lasted %0d cycles", cnt));

		read_word(ADDRBITSZ'(DT_SOCID), rd);
		expect_true(rd == 32'd4, $sformatf("SOCID read %h", rd));
		read_word(ADDRBITSZ'(DT_COUNT), rd);
		expect_true(rd == 32'd3, $sformatf("slot count read %h", rd));
		for (int k = 0; k < SLAVECOUNT; k++) begin
			read_word(ADDRBITSZ'(DT_ENTRY + 2 * k), rd);
			expect_true(rd == exp_id[k], $sformatf("slot %0d id read %h", k, rd));
			read_word(ADDRBITSZ'(DT_ENTRY + 2 * k + 1), rd);
			expect_true(rd == exp_sz[k], $sformatf("slot %0d size read %h", k, rd));
		end

		// Only byte 0 of GP_OUT exists, so sel[0] decides
		exp_out = '0;
		for (int i = 0; i < 8; i++) begin
			take_random(32, wdat);
			take_random(SELBITSZ, rnd);
			sel = rnd[SELBITSZ-1:0];
			write_word(GP_WBASE + ADDRBITSZ'(GP_OUT), wdat, sel);
			if (sel[0])
				exp_out = wdat[7:0];
			read_word(GP_WBASE + ADDRBITSZ'(GP_OUT), rd);
			expect_true(rd == ARCHBITSZ'(exp_out) && gp_o == exp_out,
				$sformatf("GP_OUT read %h gp_o %h, expected %h", rd, gp_o, exp_out));
		end
		take_random(32, wdat);
		bus_access(PI1_RWOP, GP_WBASE + ADDRBITSZ'(GP_OUT), wdat, '1, rd);
		expect_true(rd == ARCHBITSZ'(exp_out), $sformatf("swap returned %h", rd));
		exp_out = wdat[7:0];
		read_word(GP_WBASE + ADDRBITSZ'(GP_OUT), rd);
		expect_true(rd == ARCHBITSZ'(exp_out), $sformatf("after swap read %h", rd));
		for (int i = 0; i < 4; i++) begin
			take_random(GPIOCOUNT, rnd);
			gp_i = rnd[GPIOCOUNT-1:0];
			repeat (3) @(negedge clk_4x_w);
			read_word(GP_WBASE + ADDRBITSZ'(GP_IN), rd);
			expect_true(rd == ARCHBITSZ'(gp_i), $sformatf("GP_IN read %h", rd));
		end

		for (int i = 0; i < 4; i++) begin
			take_random(20, rnd);
			inv_addr = (i == 0) ? INV_WBASE : INV_WBASE + ADDRBITSZ'(rnd[19:0]);
			read_word(inv_addr, rd);
			expect_true(rd == '0 && last_stall == 0,
				$sformatf("invalid %h read %h", inv_addr, rd));
			take_random(32, wdat);
			write_word(inv_addr, wdat, '1);
		end
		read_word(GP_WBASE + ADDRBITSZ'(GP_OUT), rd);
		expect_true(rd == ARCHBITSZ'(exp_out), "GP_OUT changed by invalid write");
		read_word(GP_WBASE + ADDRBITSZ'(GP_MASK), rd);
		expect_true(rd == '0, "GP_MASK changed by invalid write");
		// A reset request from the last write would stall this read
		expect_true(last_stall == 0 && !sys_rst_o && !poweroff_o,
			"invalid write requested a reset");

		write_word(GP_WBASE + ADDRBITSZ'(GP_MASK), 32'h1, 4'h1);
		repeat (4) @(negedge clk_4x_w);
		expect_true(!irq_o, "irq_o high before any change");
		gp_i[0] = ~gp_i[0];
		wait_level(W_IRQ, 1'b1, 0, cnt);
		expect_true(cnt <= 4, $sformatf("irq_o took %0d cycles", cnt));
		repeat (6) @(negedge clk_4x_w);
		expect_true(irq_o, "irq_o not held before acknowledge");
		irq_ack_i = 1'b1;
		@(negedge clk_4x_w);
		irq_ack_i = 1'b0;
		expect_true(!irq_o, "irq_o not cleared by acknowledge");
		gp_i[1] = ~gp_i[1];
		for (int i = 0; i < 6; i++) begin
			@(negedge clk_4x_w);
			expect_true(!irq_o, "irq_o raised by an unmasked bit");
		end

		write_word(GP_WBASE + ADDRBITSZ'(GP_OUT), 32'hA5, '1);
		expect_true(gp_o == 8'hA5, "gp_o not set before warm reset");
		write_word(ADDRBITSZ'(DT_RST), 32'h2, 4'h1);
		wait_level(W_SYS_RST, 1'b1, 0, cnt);
		wait_level(W_SYS_RST, 1'b0, 0, cnt);
		expect_true(cnt == RST_CYCLES, $sformatf("warm reset lasted %0d cycles", cnt));
		expect_true(gp_o == '0, "gp_o not cleared by warm reset");

		write_word(ADDRBITSZ'(DT_RST), 32'h1, 4'h1);
		wait_level(W_POWEROFF, 1'b1, 0, cnt);
		repeat (2 * RST_CYCLES) @(negedge clk_4x_w);
		expect_true(sys_rst_o && poweroff_o, "power-off released without rst_p");
		tb_rst = 1'b1;
		repeat (2) @(negedge clk_4x_w);
		tb_rst = 1'b0;
		wait_level(W_SYS_RST, 1'b0, 0, cnt);
		expect_true(cnt == RST_CYCLES && !poweroff_o,
			$sformatf("after power-off reset lasted %0d cycles", cnt));

		$display("Errors: %0d failed checks, %0d timeouts", check_errs, timeout_errs);
		if (check_errs == 0 && timeout_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 5000) begin
			@(posedge clk_4x_w);
			cycles++;
		end
		$display("Simulation ran past its cycle limit without finishing");
		$display("Errors: %0d failed checks, %0d timeouts", check_errs, timeout_errs);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== filelist.f ====
source/soc_pkg.sv
source/pi1_if.sv
source/reset_seq.sv
source/pi1_router.sv
source/devtbl.sv
source/gpio_ctrl.sv
source/soc_top.sv
sim/tb_clk_gen.sv
sim/tb_soc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_soc_top; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_soc_top); then
	echo "$sim_out"
	echo "Simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if grep -qx "=== PASS ===" <<< "$sim_out"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
